// ==== uart_top.f ====
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_transmitter.sv
hw/uart_receiver.sv
hw/uart_status.sv
hw/uart_top.sv
sim/uart_clock_gen.sv
sim/uart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := uart_tb
FILELIST  := uart_top.f
FLAGS     := --binary --timing --assert --timescale 1ns/100ps
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/uart_tb.sv ====
// ==========================================================================
// uart testbench
// ==========================================================================

module uart_tb
    import uart_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DIV_BASE   = 2;
    localparam int WAIT_LIMIT = 5000;           // cycles, a slow frame is about 700
    localparam int SEED       = 32'h0e820a58;

    logic         clk;
    logic         reset;
    baud_sel_t    baud_sel;
    logic         tx_start;
    logic [7:0]   tx_data;
    logic         rx_en;
    logic         status_clear;
    logic         rxd;
    logic         txd;
    uart_status_t status;
    logic         loopback;
    logic         rxd_drv;
    logic [7:0]   last_rx;   // last good byte, kept in rx_data
    int           errors;
    int           checks;
    int           tests;

    uart_clock_gen clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    uart_top #(
        .DIV_BASE (DIV_BASE)
    ) uart_top_i (
        .clk          (clk),
        .reset        (reset),
        .baud_sel     (baud_sel),
        .tx_start     (tx_start),
        .tx_data      (tx_data),
        .rx_en        (rx_en),
        .status_clear (status_clear),
        .rxd          (rxd),
        .txd          (txd),
        .status       (status)
    );

    assign rxd = loopback ? txd : rxd_drv;

    // clocks per bit: 16 ticks of DIV_BASE * 2**(7-sel)
    function automatic int bit_clocks();
        return (DIV_BASE << (7 - int'(baud_sel))) * OVERSAMPLE;
    endfunction

    function automatic uart_status_t expect_status(input logic [7:0] data, input logic ready,
                                                   input logic ovr, input logic fe,
                                                   input logic pe);
        uart_status_t s;
        s                = '0;
        s.rx_data        = data;
        s.rx_ready       = ready;
        s.overrun        = ovr;
        s.ferror_seen    = fe;
        s.perror_seen    = pe;
        s.frames_bad_any = fe | pe;
        return s;
    endfunction

    task automatic check_status(input uart_status_t got, input uart_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR status: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        @(negedge clk);
        while (reset && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (reset) begin
            errors++;
            $display("reset was never released");
        end
    endtask

    // polls one status condition at the falling edge
    task automatic wait_flag(input string flag);
        int   n;
        logic hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < WAIT_LIMIT) begin
            @(negedge clk);
            if (flag == "rx_ready") hit = status.rx_ready;
            else if (flag == "overrun") hit = status.overrun;
            else if (flag == "bad") hit = status.frames_bad_any;
            else hit = !status.tx_busy;
            n++;
        end
        if (!hit) begin
            errors++;
            $display("timeout: %s did not come within %0d cycles", flag, WAIT_LIMIT);
        end
    endtask

    task automatic pulse_clear();
        @(posedge clk);
        status_clear <= 1'b1;
        @(posedge clk);
        status_clear <= 1'b0;
    endtask

    task automatic set_mode(input baud_sel_t sel, input logic loop);
        @(posedge clk);
        baud_sel <= sel;
        loopback <= loop;
        repeat (4) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] data);
        wait_flag("tx_idle");
        @(posedge clk);
        tx_start <= 1'b1;
        tx_data  <= data;
        @(posedge clk);
        tx_start <= 1'b0;
    endtask

    // glitch_pos is a data bit index in line order, -1 for none
    task automatic drive_frame(input logic [7:0] data, input logic par, input logic stop,
                               input int glitch_pos);
        logic [10:0] bits;
        int          len;
        bits = {1'b0, data, par, stop};
        len  = bit_clocks();
        for (int i = 0; i < 11; i++) begin
            for (int c = 0; c < len; c++) begin
                @(posedge clk);
                if (glitch_pos >= 0 && i == glitch_pos + 1 && c >= len * 3 / 4) begin
                    rxd_drv <= ~bits[10];  // flips after the sample point
                end else begin
                    rxd_drv <= bits[10];
                end
            end
            bits = {bits[9:0], 1'b1};
        end
        @(posedge clk);
        rxd_drv <= 1'b1;
        repeat (2 * len) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        @(negedge clk);
        check_line("txd", txd, 1'b1);
        check_status(status, '0);
        finish_test("reset", err0);
    endtask

    task automatic test_loopback();
        int         err0;
        logic [7:0] b;
        err0 = errors;
        for (int s = 7; s >= 6; s--) begin
            set_mode(baud_sel_t'(s), 1'b1);
            repeat (20) begin
                b = 8'($urandom());
                pulse_clear();
                send_byte(b);
                wait_flag("rx_ready");
                wait_flag("tx_idle");
                last_rx = b;
                check_byte("status.rx_data", status.rx_data, b);
                check_status(status, expect_status(b, 1'b1, 1'b0, 1'b0, 1'b0));
            end
        end
        finish_test("loopback", err0);
    endtask

    task automatic test_parity();
        int         err0;
        logic [7:0] b;
        err0 = errors;
        set_mode(3'd7, 1'b0);
        b = 8'($urandom());
        pulse_clear();
        drive_frame(b, ~(^b), 1'b1, -1);
        wait_flag("bad");
        check_status(status, expect_status(last_rx, 1'b0, 1'b0, 1'b0, 1'b1));
        pulse_clear();
        @(negedge clk);
        check_status(status, expect_status(last_rx, 1'b0, 1'b0, 1'b0, 1'b0));
        finish_test("parity error", err0);
    endtask

    task automatic test_framing();
        int err0;
        err0 = errors;
        set_mode(3'd7, 1'b0);
        pulse_clear();
        drive_frame(8'h5a, ^8'h5a, 1'b0, -1);  // low stop bit
        wait_flag("bad");
        check_status(status, expect_status(last_rx, 1'b0, 1'b0, 1'b1, 1'b0));
        pulse_clear();
        // lsb 0 rises at the glitch and parity is 1, so no new start edge follows
        drive_frame(8'ha8, ^8'ha8, 1'b1, 7);
        wait_flag("bad");
        check_status(status, expect_status(last_rx, 1'b0, 1'b0, 1'b1, 1'b0));
        finish_test("framing error", err0);
    endtask

    task automatic test_overrun();
        int         err0;
        logic [7:0] b1;
        logic [7:0] b2;
        err0 = errors;
        set_mode(3'd7, 1'b1);
        b1 = 8'($urandom());
        b2 = 8'($urandom());
        pulse_clear();
        send_byte(b1);
        wait_flag("rx_ready");
        send_byte(b2);
        wait_flag("overrun");
        wait_flag("tx_idle");
        last_rx = b2;
        check_byte("status.rx_data", status.rx_data, b2);
        check_status(status, expect_status(b2, 1'b1, 1'b1, 1'b0, 1'b0));
        finish_test("overrun", err0);
    endtask

    task automatic test_ignored();
        int         err0;
        logic [7:0] b1;
        logic [7:0] b2;
        err0 = errors;
        set_mode(3'd7, 1'b0);
        rx_en <= 1'b0;
        pulse_clear();
        drive_frame(8'h3c, ^8'h3c, 1'b1, -1);
        @(negedge clk);
        check_status(status, expect_status(last_rx, 1'b0, 1'b0, 1'b0, 1'b0));
        set_mode(3'd7, 1'b1);
        rx_en <= 1'b1;
        b1 = 8'($urandom());
        b2 = 8'($urandom());
        @(posedge clk);
        tx_start <= 1'b1;
        tx_data  <= b1;
        @(posedge clk);
        tx_start <= 1'b0;
        repeat (3) @(posedge clk);
        tx_start <= 1'b1;  // transmitter is busy by now
        tx_data  <= b2;
        @(posedge clk);
        tx_start <= 1'b0;
        @(negedge clk);
        check_line("status.tx_busy", status.tx_busy, 1'b1);
        wait_flag("rx_ready");
        wait_flag("tx_idle");
        repeat (2 * 11 * bit_clocks()) @(posedge clk);  // room for a second frame
        @(negedge clk);
        last_rx = b1;
        check_status(status, expect_status(b1, 1'b1, 1'b0, 1'b0, 1'b0));
        finish_test("ignored inputs", err0);
    endtask

    initial begin
        baud_sel     = 3'd7;
        tx_start     = 1'b0;
        tx_data      = '0;
        rx_en        = 1'b1;
        status_clear = 1'b0;
        rxd_drv      = 1'b1;
        loopback     = 1'b1;
        last_rx      = '0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        void'($urandom(SEED));
        wait_reset();
        test_reset();
        test_loopback();
        test_parity();
        test_framing();
        test_overrun();
        test_ignored();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(2_000_000);
        $display("watchdog: the run did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== sim/uart_clock_gen.sv ====
// ==========================================================================
// testbench clock and reset
// ==========================================================================

module uart_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;
    always #5 clk = ~clk;  // 10 ns period

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== hw/uart_top.sv ====
// ==========================================================================
// uart top level
// ==========================================================================

module uart_top
    import uart_pkg::*;
#(
    parameter int DIV_BASE = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  baud_sel_t            baud_sel,
    input  logic                 tx_start,
    input  logic [DATA_BITS-1:0] tx_data,
    input  logic                 rx_en,
    input  logic                 status_clear,
    input  logic                 rxd,
    output logic                 txd,
    output uart_status_t         status
);

    logic      tick;       // shared 16x oversampling tick
    logic      tx_busy;
    logic      rx_event;
    rx_frame_t rx_result;

    uart_baud_gen #(
        .DIV_BASE (DIV_BASE)
    ) uart_baud_gen_i (
        .clk      (clk),
        .reset    (reset),
        .baud_sel (baud_sel),
        .tick     (tick)
    );

    uart_transmitter uart_transmitter_i (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

    uart_receiver uart_receiver_i (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .rx_en     (rx_en),
        .rxd       (rxd),
        .rx_event  (rx_event),
        .rx_result (rx_result)
    );

    uart_status uart_status_i (
        .clk          (clk),
        .reset        (reset),
        .tx_busy      (tx_busy),
        .rx_event     (rx_event),
        .rx_result    (rx_result),
        .status_clear (status_clear),
        .status       (status)
    );

endmodule

// ==== hw/uart_status.sv ====
// ==========================================================================
// uart status word
// ==========================================================================

module uart_status
    import uart_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         tx_busy,
    input  logic         rx_event,
    input  rx_frame_t    rx_result,
    input  logic         status_clear,
    output uart_status_t status
);

    uart_status_t st_q;
    uart_status_t st_d;

    always_comb begin
        st_d         = st_q;
        st_d.tx_busy = tx_busy;
        if (rx_event) begin
            if (rx_result.ferror || rx_result.perror) begin
                // bad frame keeps the last good byte
                st_d.ferror_seen = st_q.ferror_seen | rx_result.ferror;
                st_d.perror_seen = st_q.perror_seen | rx_result.perror;
            end else begin
                st_d.rx_data  = rx_result.data;
                st_d.rx_ready = 1'b1;
                st_d.overrun  = st_q.overrun | st_q.rx_ready;  // previous byte unread
            end
        end
        // clear wins over a frame in the same cycle
        if (status_clear) begin
            st_d.rx_ready    = 1'b0;
            st_d.overrun     = 1'b0;
            st_d.ferror_seen = 1'b0;
            st_d.perror_seen = 1'b0;
        end
        st_d.frames_bad_any = st_d.ferror_seen | st_d.perror_seen;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            st_q <= '0;
        end else begin
            st_q <= st_d;
        end
    end

    assign status = st_q;

endmodule

// ==== hw/uart_receiver.sv ====
// ==========================================================================
// uart receiver
// ==========================================================================

module uart_receiver
    import uart_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      tick,
    input  logic      rx_en,
    input  logic      rxd,
    output logic      rx_event,
    output rx_frame_t rx_result
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    rx_state_t            state;
    logic [2:0]           rxd_sync;   // two sync flops and one of history
    logic [TICK_W-1:0]    tick_cnt;   // ticks seen so far in this bit
    logic [2:0]           bit_idx;
    logic                 bit_val;
    logic [DATA_BITS-1:0] data;
    logic                 ferror;
    logic                 perror;
    logic                 rxd_s;
    logic                 rxd_fall;
    logic                 sample_pt;
    logic                 check_pt;
    logic                 bit_end;

    assign rxd_s    = rxd_sync[1];
    assign rxd_fall = rxd_sync[2] & ~rxd_sync[1];

    // tick 8 samples, ticks 9, 11, 13 and 15 check stability, tick 16 ends the bit
    assign sample_pt = tick && (tick_cnt == TICK_W'(SAMPLE_TICK - 1));
    assign check_pt  = tick && (tick_cnt > TICK_W'(SAMPLE_TICK - 1)) && !tick_cnt[0];
    assign bit_end   = tick && (tick_cnt == TICK_W'(OVERSAMPLE - 1));

    assign rx_result = '{data: data, ferror: ferror, perror: perror};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxd_sync <= '1;
        end else begin
            rxd_sync <= {rxd_sync[1:0], rxd};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            rx_event <= 1'b0;
            ferror   <= 1'b0;
            perror   <= 1'b0;
        end else begin
            rx_event <= 1'b0;
            if (!rx_en) begin
                state <= RX_IDLE;
            end else if (state == RX_IDLE) begin
                if (rxd_fall) begin
                    state    <= RX_START;
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                end
            end else if (tick) begin
                tick_cnt <= tick_cnt + 1'b1;
                if (sample_pt) begin
                    case (state)
                        RX_START: begin
                            if (rxd_s) state <= RX_IDLE;  // false start, no event
                        end
                        RX_PARITY: begin
                            if (rxd_s != ^data) begin     // even parity over data
                                state    <= RX_IDLE;
                                rx_event <= 1'b1;
                                ferror   <= 1'b0;
                                perror   <= 1'b1;
                            end
                        end
                        RX_STOP: begin
                            if (!rxd_s) begin
                                state    <= RX_IDLE;
                                rx_event <= 1'b1;
                                ferror   <= 1'b1;
                                perror   <= 1'b0;
                            end
                        end
                        default: ;
                    endcase
                end else if (check_pt && (rxd_s != bit_val)) begin
                    // value moved after the sample point
                    state    <= RX_IDLE;
                    rx_event <= 1'b1;
                    ferror   <= 1'b1;
                    perror   <= 1'b0;
                end else if (bit_end) begin
                    case (state)
                        RX_START:  state <= RX_DATA;
                        RX_DATA: begin
                            bit_idx <= bit_idx + 1'b1;
                            if (bit_idx == 3'(DATA_BITS - 1)) state <= RX_PARITY;
                        end
                        RX_PARITY: state <= RX_STOP;
                        RX_STOP: begin
                            state    <= RX_IDLE;
                            rx_event <= 1'b1;   // good frame
                            ferror   <= 1'b0;
                            perror   <= 1'b0;
                        end
                        default:   state <= RX_IDLE;
                    endcase
                end
            end
        end
    end

    // frame payload, cleared on each new start edge
    always_ff @(posedge clk) begin
        if (state == RX_IDLE && rxd_fall) begin
            data <= '0;
        end else if (state == RX_DATA && sample_pt) begin
            data[3'(DATA_BITS - 1) - bit_idx] <= rxd_s;  // msb arrives first
        end
        if (sample_pt) begin
            bit_val <= rxd_s;
        end
    end

    // the status block counts one frame per cycle of rx_event
    a_event_pulse: assert property (@(posedge clk) disable iff (reset) rx_event |=> !rx_event);

endmodule

// ==== hw/uart_transmitter.sv ====
// ==========================================================================
// uart transmitter
// ==========================================================================

module uart_transmitter
    import uart_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tick,
    input  logic                 tx_start,
    input  logic [DATA_BITS-1:0] tx_data,
    output logic                 txd,
    output logic                 tx_busy
);

    localparam int BIT_W = $clog2(FRAME_BITS);

    logic [FRAME_BITS-1:0] shreg;     // msb is on the line
    logic [TICK_W-1:0]     tick_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic                  last_tick;

    assign txd       = shreg[FRAME_BITS-1];
    assign last_tick = (tick_cnt == TICK_W'(OVERSAMPLE - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            shreg    <= '1;           // idle line is high
            tx_busy  <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                // start, data msb first, even parity, stop
                shreg    <= {1'b0, tx_data, ^tx_data, 1'b1};
                tx_busy  <= 1'b1;
                tick_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;  // wraps after 16
            if (last_tick) begin
                shreg <= {shreg[FRAME_BITS-2:0], 1'b1};
                if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                    tx_busy <= 1'b0;       // stop bit done
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // the line must be back at idle once the frame is over
    a_idle_high: assert property (@(posedge clk) disable iff (reset) !tx_busy |-> txd);

endmodule

// ==== hw/uart_baud_gen.sv ====
// ==========================================================================
// baud tick generator
// ==========================================================================

module uart_baud_gen
    import uart_pkg::*;
#(
    parameter int DIV_BASE = 2  // at least 2
) (
    input  logic      clk,
    input  logic      reset,
    input  baud_sel_t baud_sel,
    output logic      tick
);

    localparam int MAX_DIV = DIV_BASE << 7;
    localparam int CNT_W   = $clog2(MAX_DIV);

    logic [31:0]      divisor;
    logic [CNT_W-1:0] cnt;
    logic             running;
    baud_sel_t        sel_q;
    logic             reload;

    assign divisor = 32'(DIV_BASE) << (3'd7 - baud_sel);

    // first cycle after reset, or a new selection, restarts the period
    assign reload = !running || (baud_sel != sel_q);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt     <= '0;
            tick    <= 1'b0;
            running <= 1'b0;
            sel_q   <= '0;
        end else begin
            running <= 1'b1;
            sel_q   <= baud_sel;
            if (reload) begin
                cnt  <= CNT_W'(divisor - 32'd2);  // this cycle already counts
                tick <= 1'b0;
            end else if (cnt == '0) begin
                cnt  <= CNT_W'(divisor - 32'd1);
                tick <= 1'b1;
            end else begin
                cnt  <= cnt - 1'b1;
                tick <= 1'b0;
            end
        end
    end

    // tx and rx count ticks, a stretched pulse would count twice
    a_tick_single: assert property (@(posedge clk) disable iff (reset) tick |=> !tick);

endmodule

// ==== hw/uart_pkg.sv ====
// ==========================================================================
// uart shared types and constants
// ==========================================================================

package uart_pkg;

    // baud selection, s gives a tick every DIV_BASE * 2**(7-s) clocks
    typedef logic [2:0] baud_sel_t;

    localparam int OVERSAMPLE  = 16;               // ticks per bit
    localparam int TICK_W      = $clog2(OVERSAMPLE);
    localparam int SAMPLE_TICK = 8;                // bit value taken here
    localparam int DATA_BITS   = 8;
    localparam int FRAME_BITS  = 11;               // start, 8 data, parity, stop

    // result of one received frame
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic                 ferror;
        logic                 perror;
    } rx_frame_t;

    // status word seen from outside
    typedef struct packed {
        logic [DATA_BITS-1:0] rx_data;
        logic                 rx_ready;
        logic                 overrun;
        logic                 ferror_seen;
        logic                 perror_seen;
        logic                 tx_busy;
        logic                 frames_bad_any;  // any sticky error flag set
    } uart_status_t;

endpackage
